// File: bench/ntm_diff_patterns.hex
// Case count, then per case: size_i size_j modulus, input rows, expected rows
// All values hex, one matrix row per line
3
2 3 0011
1 5 9
3 a 10
1 4 4
3 7 6
2 4 0064
32 14 5a 0a
05 05 03 63
32 46 46 14
05 00 62 60
3 2 fff1
1000 0800
0001 fff0
7fff 7fff
1000 f7f1
0001 ffef
7fff 0000

// File: sim.f
logic/ntm_diff_pkg.sv
logic/ntm_vector_differentiation.sv
logic/ntm_matrix_differentiation.sv
logic/ntm_shared_memory.sv
logic/ntm_axil_slave.sv
logic/ntm_diff_top.sv
bench/ntm_diff_tb.sv

// File: Makefile
# Verilator build and run of the matrix differentiation testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := ntm_diff_tb
FILELIST  := sim.f
PASS_MSG  := Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: bench/ntm_diff_tb.sv
/*
 * Testbench of the matrix differentiation accelerator. It drives the AXI4-Lite
 * port from the vectors in the pattern file, runs the engine on each case
 * and reads the output bank back. Response back-pressure is random.
 */
`default_nettype none

module ntm_diff_tb
  import ntm_diff_pkg::*;
();

  // Cycles allowed for any single handshake
  localparam int LIMIT = 200;
  // Status polls allowed per engine run
  localparam int POLL_LIMIT = 100;

  logic                  CLK;
  logic                  RST;
  logic                  awvalid;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [DATA_W-1:0]     wdata;
  logic                  wready;
  logic                  bvalid;
  axi_resp_t             bresp;
  logic                  bready;
  logic                  arvalid;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arready;
  logic                  rvalid;
  logic [DATA_W-1:0]     rdata;
  axi_resp_t             rresp;
  logic                  rready;

  // Case count, then sizes, modulus, inputs and expected words per case
  logic [DATA_W-1:0]     pat [0:255];
  int                    seed;

  ntm_diff_top dut (
    .CLK, .RST,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
    .bvalid, .bresp, .bready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("Run stopped at time %0t: %s", $time, reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s response is %b, expected %b", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "response mismatch");
    end
  endtask

  // Back-pressure of 0 to 3 cycles
  function automatic int pick_delay();
    int r;
    r = $random(seed);
    return r & 3;
  endfunction

  function automatic logic [AXI_ADDR_W-1:0] csr_addr(input logic [2:0] sel);
    return {1'b0, 4'b0000, sel};
  endfunction

  function automatic logic [AXI_ADDR_W-1:0] mem_addr(input logic bank,
      input logic [DIM_W-1:0] row, input logic [DIM_W-1:0] col);
    return {1'b1, bank, row, col};
  endfunction

  // Row difference modulo m, previous element zero at row start
  function automatic logic [DATA_W-1:0] row_diff(input logic [DATA_W-1:0] cur,
      input logic [DATA_W-1:0] prev, input logic [DATA_W-1:0] m);
    int d;
    d = int'(cur) - int'(prev);
    if (d < 0) begin
      d = d + int'(m);
    end
    return d[DATA_W-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite transfers, each entered just after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output axi_resp_t resp);
    int n;
    int hold;
    n = 0;
    hold = pick_delay();
    awvalid <= 1'b1;
    awaddr <= addr;
    wvalid <= 1'b1;
    wdata <= data;
    do begin
      @(posedge CLK);
      n++;
      if (n > LIMIT) abort_run("timed out waiting for awready and wready");
    end while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge CLK);
      n++;
      if (n > LIMIT) abort_run("timed out waiting for bvalid");
    end while (!bvalid);
    // Response must survive back-pressure
    repeat (hold) begin
      @(posedge CLK);
      if (!bvalid) abort_run("bvalid dropped before bready was given");
    end
    bready <= 1'b1;
    @(posedge CLK);
    if (!bvalid) abort_run("bvalid dropped before bready was given");
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output axi_resp_t resp);
    int n;
    int hold;
    logic [DATA_W-1:0] first;
    n = 0;
    hold = pick_delay();
    arvalid <= 1'b1;
    araddr <= addr;
    do begin
      @(posedge CLK);
      n++;
      if (n > LIMIT) abort_run("timed out waiting for arready");
    end while (!arready);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge CLK);
      n++;
      if (n > LIMIT) abort_run("timed out waiting for rvalid");
    end while (!rvalid);
    first = rdata;
    repeat (hold) begin
      @(posedge CLK);
      if (!rvalid) abort_run("rvalid dropped before rready was given");
      if (rdata !== first) abort_run("rdata changed while the response was held");
    end
    rready <= 1'b1;
    @(posedge CLK);
    if (!rvalid) abort_run("rvalid dropped before rready was given");
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic write_expect(input logic [AXI_ADDR_W-1:0] addr,
      input logic [DATA_W-1:0] data, input axi_resp_t exp, input string what);
    axi_resp_t resp;
    axi_write(addr, data, resp);
    check_resp(resp, exp, what);
  endtask

  task automatic read_expect(input logic [AXI_ADDR_W-1:0] addr,
      input logic [DATA_W-1:0] exp, input axi_resp_t exp_resp, input string what);
    logic [DATA_W-1:0] data;
    axi_resp_t resp;
    axi_read(addr, data, resp);
    check_resp(resp, exp_resp, what);
    check_word(data, exp, what);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int n_cases;
    int ptr;
    int si;
    int sj;
    int base;
    int out_base;
    int polls;
    logic [DATA_W-1:0] modv;
    logic [DATA_W-1:0] prev;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] word;
    axi_resp_t resp;
    seed = 32'h856c_5671;
    RST = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    $readmemh("bench/ntm_diff_patterns.hex", pat);
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);

    // Register readback, status is read only
    read_expect(csr_addr(REG_STATUS), 16'h0000, RESP_OKAY, "status after reset");
    write_expect(csr_addr(REG_SIZE_I), 16'h0005, RESP_OKAY, "size_i write");
    write_expect(csr_addr(REG_SIZE_J), 16'h0007, RESP_OKAY, "size_j write");
    write_expect(csr_addr(REG_MODULO), 16'h1234, RESP_OKAY, "modulus write");
    read_expect(csr_addr(REG_SIZE_I), 16'h0005, RESP_OKAY, "size_i readback");
    read_expect(csr_addr(REG_SIZE_J), 16'h0007, RESP_OKAY, "size_j readback");
    read_expect(csr_addr(REG_MODULO), 16'h1234, RESP_OKAY, "modulus readback");
    write_expect(csr_addr(REG_STATUS), 16'h0003, RESP_SLVERR, "status write");

    if ($isunknown(pat[0]) || pat[0] == '0) abort_run("pattern file is missing or empty");
    n_cases = int'(pat[0]);
    ptr = 1;
    for (int c = 0; c < n_cases; c++) begin
      si = int'(pat[ptr]);
      sj = int'(pat[ptr + 1]);
      modv = pat[ptr + 2];
      base = ptr + 3;
      out_base = base + si * sj;
      write_expect(csr_addr(REG_SIZE_I), pat[ptr], RESP_OKAY, "size_i write");
      write_expect(csr_addr(REG_SIZE_J), pat[ptr + 1], RESP_OKAY, "size_j write");
      write_expect(csr_addr(REG_MODULO), modv, RESP_OKAY, "modulus write");
      // Input bank load
      for (int r = 0; r < si; r++) begin
        for (int k = 0; k < sj; k++) begin
          write_expect(mem_addr(BANK_IN, r[DIM_W-1:0], k[DIM_W-1:0]),
                       pat[base + r * sj + k], RESP_OKAY, "input load");
        end
      end
      write_expect(csr_addr(REG_CTRL), 16'h0001, RESP_OKAY, "start");
      read_expect(csr_addr(REG_STATUS), 16'h0001, RESP_OKAY, "status while running");
      // Host reads compete with the engine for the memory
      for (int r = 0; r < si; r++) begin
        for (int k = 0; k < sj; k++) begin
          read_expect(mem_addr(BANK_IN, r[DIM_W-1:0], k[DIM_W-1:0]),
                      pat[base + r * sj + k], RESP_OKAY, "input read during run");
        end
      end
      polls = 0;
      do begin
        axi_read(csr_addr(REG_STATUS), word, resp);
        check_resp(resp, RESP_OKAY, "status poll");
        polls++;
        if (polls > POLL_LIMIT) abort_run("timed out waiting for the engine to finish");
      end while (!word[1]);
      check_word(word, 16'h0002, "status after run");
      // Output bank against the file and the row rule
      for (int r = 0; r < si; r++) begin
        for (int k = 0; k < sj; k++) begin
          prev = (k == 0) ? '0 : pat[base + r * sj + k - 1];
          exp = pat[out_base + r * sj + k];
          if (exp !== row_diff(pat[base + r * sj + k], prev, modv)) begin
            abort_run("pattern file entry breaks the row difference rule");
          end
          read_expect(mem_addr(BANK_OUT, r[DIM_W-1:0], k[DIM_W-1:0]), exp, RESP_OKAY,
                      "output word");
        end
      end
      ptr = out_base + si * sj;
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/ntm_diff_top.sv
/*
 * Top level of the accelerator. Host port, scratch memory and
 * differentiation engine, with one AXI4-Lite slave port outside.
 */
`default_nettype none

module ntm_diff_top
  import ntm_diff_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  awvalid,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  output logic                  awready,
  input  logic                  wvalid,
  input  logic [DATA_W-1:0]     wdata,
  output logic                  wready,
  output logic                  bvalid,
  output axi_resp_t             bresp,
  input  logic                  bready,
  input  logic                  arvalid,
  input  logic [AXI_ADDR_W-1:0] araddr,
  output logic                  arready,
  output logic                  rvalid,
  output logic [DATA_W-1:0]     rdata,
  output axi_resp_t             rresp,
  input  logic                  rready
);

  //////////////////////////////////////////////////////////////////////
  // Internal buses
  //////////////////////////////////////////////////////////////////////

  mem_req_t          host_req;
  mem_req_t          eng_req;
  logic              host_gnt;
  logic              eng_gnt;
  logic [DATA_W-1:0] mem_rdata;
  diff_cfg_t         cfg;
  logic              start;
  logic              busy;
  logic              done;

  // Host side
  ntm_axil_slave u_slave (
    .CLK, .RST,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
    .bvalid, .bresp, .bready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
    .host_req, .host_gnt, .mem_rdata,
    .cfg, .start, .busy, .done
  );

  // Shared scratch memory
  ntm_shared_memory u_memory (
    .CLK, .RST,
    .host_req, .eng_req, .host_gnt, .eng_gnt, .mem_rdata
  );

  // Engine side
  ntm_matrix_differentiation u_engine (
    .CLK, .RST,
    .start, .cfg, .eng_req, .eng_gnt, .mem_rdata, .busy, .done
  );

endmodule

`default_nettype wire

// File: logic/ntm_axil_slave.sv
/*
 * AXI4-Lite slave of the accelerator. Register addresses are served here,
 * memory addresses become requests to the shared scratch memory.
 * One transaction at a time, reads and writes taken in turn.
 */
`default_nettype none

module ntm_axil_slave
  import ntm_diff_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  awvalid,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  output logic                  awready,
  input  logic                  wvalid,
  input  logic [DATA_W-1:0]     wdata,
  output logic                  wready,
  output logic                  bvalid,
  output axi_resp_t             bresp,
  input  logic                  bready,
  input  logic                  arvalid,
  input  logic [AXI_ADDR_W-1:0] araddr,
  output logic                  arready,
  output logic                  rvalid,
  output logic [DATA_W-1:0]     rdata,
  output axi_resp_t             rresp,
  input  logic                  rready,
  output mem_req_t              host_req,
  input  logic                  host_gnt,
  input  logic [DATA_W-1:0]     mem_rdata,
  output diff_cfg_t             cfg,
  output logic                  start,
  input  logic                  busy,
  input  logic                  done
);

  typedef enum logic [1:0] {S_IDLE, S_MEM, S_RESP} state_t;

  state_t            state;
  // Last accepted transaction was a write
  logic              last_wr;
  logic              pick_wr;
  ntm_addr_u         addr;
  // Read data still comes straight from memory
  logic              rd_live;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] reg_rdata;
  axi_resp_t         reg_rresp;
  axi_resp_t         reg_wresp;

  //////////////////////////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////////////////////////

  // Write needs both channels, round robin against reads
  assign pick_wr = awvalid && wvalid && (!arvalid || !last_wr);
  assign awready = (state == S_IDLE) && pick_wr;
  assign wready = awready;
  assign arready = (state == S_IDLE) && arvalid && !pick_wr;

  // Address of whichever side is taken
  assign addr = awready ? awaddr : araddr;

  // First response cycle of a memory read bypasses the holding register
  assign rdata = rd_live ? mem_rdata : rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Register decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_rdata = '0;
    reg_rresp = RESP_OKAY;
    reg_wresp = RESP_OKAY;
    case (addr.csr.sel)
      REG_CTRL: reg_rdata = '0;
      // Status is read only
      REG_STATUS: begin
        reg_rdata = DATA_W'({done, busy});
        reg_wresp = RESP_SLVERR;
      end
      REG_SIZE_I: reg_rdata = DATA_W'(cfg.size_i);
      REG_SIZE_J: reg_rdata = DATA_W'(cfg.size_j);
      REG_MODULO: reg_rdata = cfg.modulo;
      default: begin
        reg_rresp = RESP_SLVERR;
        reg_wresp = RESP_SLVERR;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Transaction FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= S_IDLE;
      last_wr <= 1'b0;
      bvalid <= 1'b0;
      bresp <= RESP_OKAY;
      rvalid <= 1'b0;
      rresp <= RESP_OKAY;
      rdata_q <= '0;
      rd_live <= 1'b0;
      host_req <= '0;
      start <= 1'b0;
      cfg <= '{size_i: 4'd1, size_j: 4'd1, modulo: '1};
    end else begin
      // Start is a one-cycle pulse
      start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (awready) begin
            last_wr <= 1'b1;
            if (addr.mem.region) begin
              host_req <= '{1'b1, 1'b1, {addr.mem.bank, addr.mem.row, addr.mem.col}, wdata};
              state <= S_MEM;
            end else begin
              case (addr.csr.sel)
                // Ignored while the engine runs
                REG_CTRL: start <= wdata[0] && !busy;
                REG_SIZE_I: cfg.size_i <= wdata[DIM_W:0];
                REG_SIZE_J: cfg.size_j <= wdata[DIM_W:0];
                REG_MODULO: cfg.modulo <= wdata;
                default: ;
              endcase
              bvalid <= 1'b1;
              bresp <= reg_wresp;
              state <= S_RESP;
            end
          end else if (arready) begin
            last_wr <= 1'b0;
            if (addr.mem.region) begin
              host_req <= '{1'b1, 1'b0, {addr.mem.bank, addr.mem.row, addr.mem.col}, '0};
              state <= S_MEM;
            end else begin
              rvalid <= 1'b1;
              rresp <= reg_rresp;
              rdata_q <= reg_rdata;
              state <= S_RESP;
            end
          end
        end
        // Wait for the arbiter
        S_MEM: begin
          if (host_gnt) begin
            host_req.valid <= 1'b0;
            if (host_req.we) begin
              bvalid <= 1'b1;
              bresp <= RESP_OKAY;
            end else begin
              rvalid <= 1'b1;
              rresp <= RESP_OKAY;
              rd_live <= 1'b1;
            end
            state <= S_RESP;
          end
        end
        // Hold the response until taken
        S_RESP: begin
          rd_live <= 1'b0;
          if (rd_live) begin
            rdata_q <= mem_rdata;
          end
          if (bvalid && bready) begin
            bvalid <= 1'b0;
            state <= S_IDLE;
          end
          if (rvalid && rready) begin
            rvalid <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Write response stays up under back-pressure
  a_bvalid_hold: assert property (
    @(posedge CLK) disable iff (RST) bvalid && !bready |=> bvalid
  );

endmodule

`default_nettype wire

// File: logic/ntm_shared_memory.sv
/*
 * Two-bank scratch memory shared by the host port and the engine.
 * A round-robin arbiter grants one request per cycle; read data
 * is registered and valid in the cycle after the grant.
 */
`default_nettype none

module ntm_shared_memory
  import ntm_diff_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  mem_req_t          host_req,
  input  mem_req_t          eng_req,
  output logic              host_gnt,
  output logic              eng_gnt,
  output logic [DATA_W-1:0] mem_rdata
);

  // Input bank then output bank
  logic [DATA_W-1:0] mem [2**MEM_ADDR_W];
  // Engine wins a tie when set
  logic              eng_first;
  mem_req_t          sel_req;

  //////////////////////////////////////////////////////////////////////
  // Arbiter
  //////////////////////////////////////////////////////////////////////

  assign host_gnt = host_req.valid && (!eng_req.valid || !eng_first);
  assign eng_gnt = eng_req.valid && (!host_req.valid || eng_first);

  // Granted request
  assign sel_req = eng_gnt ? eng_req : host_req;

  // Priority moves to the side not just served
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      eng_first <= 1'b0;
    end else if (host_gnt || eng_gnt) begin
      eng_first <= host_gnt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Single port, read data shared by both requesters
  always_ff @(posedge CLK) begin
    if (host_gnt || eng_gnt) begin
      if (sel_req.we) begin
        mem[sel_req.addr] <= sel_req.wdata;
      end else begin
        mem_rdata <= mem[sel_req.addr];
      end
    end
  end

  // One port, so never two grants
  a_one_grant: assert property (
    @(posedge CLK) disable iff (RST) !(host_gnt && eng_gnt)
  );

endmodule

`default_nettype wire

// File: logic/ntm_matrix_differentiation.sv
/*
 * Differentiation engine. Walks the matrix row by row, reads each input
 * word from the scratch memory, passes it through the vector unit and
 * writes the difference to the output bank. Start with a one-cycle pulse.
 */
`default_nettype none

module ntm_matrix_differentiation
  import ntm_diff_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  diff_cfg_t         cfg,
  output mem_req_t          eng_req,
  input  logic              eng_gnt,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              busy,
  output logic              done
);

  typedef enum logic [2:0] {S_IDLE, S_RD, S_SAMPLE, S_DIFF, S_WR} state_t;

  state_t            state;
  // Configuration held for the whole run
  diff_cfg_t         cfg_q;
  logic [DIM_W-1:0]  row;
  logic [DIM_W-1:0]  col;
  logic [DIM_W-1:0]  next_row;
  logic [DIM_W-1:0]  next_col;
  logic              last_col;
  logic              last_elem;
  logic              row_first;
  logic              sample_valid;
  logic              diff_valid;
  logic [DATA_W-1:0] diff;

  //////////////////////////////////////////////////////////////////////
  // Index walk
  //////////////////////////////////////////////////////////////////////

  assign last_col = {1'b0, col} == cfg_q.size_j - 1'b1;
  assign last_elem = last_col && ({1'b0, row} == cfg_q.size_i - 1'b1);

  // Column first, then row
  assign next_col = last_col ? '0 : col + 1'b1;
  assign next_row = last_col ? row + 1'b1 : row;

  // Read data is on mem_rdata in this state
  assign sample_valid = state == S_SAMPLE;
  // Row restarts against zero
  assign row_first = col == '0;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= S_IDLE;
      cfg_q <= '0;
      row <= '0;
      col <= '0;
      busy <= 1'b0;
      done <= 1'b0;
      eng_req <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            cfg_q <= cfg;
            row <= '0;
            col <= '0;
            busy <= 1'b1;
            done <= 1'b0;
            // First element of the input bank
            eng_req <= '{1'b1, 1'b0, {BANK_IN, {DIM_W{1'b0}}, {DIM_W{1'b0}}}, '0};
            state <= S_RD;
          end
        end
        // Input word request in flight
        S_RD: begin
          if (eng_gnt) begin
            eng_req.valid <= 1'b0;
            state <= S_SAMPLE;
          end
        end
        S_SAMPLE: state <= S_DIFF;
        // Difference registered by the unit
        S_DIFF: begin
          if (diff_valid) begin
            eng_req <= '{1'b1, 1'b1, {BANK_OUT, row, col}, diff};
            state <= S_WR;
          end
        end
        S_WR: begin
          if (eng_gnt) begin
            if (last_elem) begin
              eng_req.valid <= 1'b0;
              busy <= 1'b0;
              done <= 1'b1;
              state <= S_IDLE;
            end else begin
              row <= next_row;
              col <= next_col;
              // Next read goes out straight away
              eng_req <= '{1'b1, 1'b0, {BANK_IN, next_row, next_col}, '0};
              state <= S_RD;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Vector unit
  //////////////////////////////////////////////////////////////////////

  ntm_vector_differentiation u_vector (
    .CLK          (CLK),
    .RST          (RST),
    .row_first    (row_first),
    .sample_valid (sample_valid),
    .sample       (mem_rdata),
    .modulo       (cfg_q.modulo),
    .diff         (diff),
    .diff_valid   (diff_valid)
  );

  // Memory only touched during a run
  a_req_busy: assert property (
    @(posedge CLK) disable iff (RST) eng_req.valid |-> busy
  );

endmodule

`default_nettype wire

// File: logic/ntm_vector_differentiation.sv
/*
 * Per-element modular difference. Each sample is taken against the
 * previous sample of its row, or against zero when row_first is set.
 * The result follows one cycle later with diff_valid.
 */
`default_nettype none

module ntm_vector_differentiation
  import ntm_diff_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              row_first,
  input  logic              sample_valid,
  input  logic [DATA_W-1:0] sample,
  input  logic [DATA_W-1:0] modulo,
  output logic [DATA_W-1:0] diff,
  output logic              diff_valid
);

  // Previous element of the current row
  logic [DATA_W-1:0] prev;
  logic [DATA_W-1:0] base;
  logic [DATA_W-1:0] delta;

  //////////////////////////////////////////////////////////////////////
  // Difference
  //////////////////////////////////////////////////////////////////////

  assign base = row_first ? '0 : prev;
  // Wraps when sample < base, fixed by the modulus below
  assign delta = sample - base;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prev <= '0;
      diff <= '0;
      diff_valid <= 1'b0;
    end else begin
      diff_valid <= sample_valid;
      if (sample_valid) begin
        prev <= sample;
        // Negative difference, bring back into range
        if (sample < base) begin
          diff <= delta + modulo;
        end else begin
          diff <= delta;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/ntm_diff_pkg.sv
/*
 * Shared sizes, register map and bus types of the matrix differentiation
 * accelerator. Every other file imports this package.
 */
`default_nettype none

package ntm_diff_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Element and AXI data width
  localparam int DATA_W = 16;
  // Row or column index, up to 8 by 8
  localparam int DIM_W = 3;
  // Word address on the host port
  localparam int AXI_ADDR_W = 8;
  // Bank, row and column
  localparam int MEM_ADDR_W = 7;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] REG_CTRL = 3'd0;
  localparam logic [2:0] REG_STATUS = 3'd1;
  localparam logic [2:0] REG_SIZE_I = 3'd2;
  localparam logic [2:0] REG_SIZE_J = 3'd3;
  localparam logic [2:0] REG_MODULO = 3'd4;

  // Scratch memory banks
  localparam logic BANK_IN = 1'b0;
  localparam logic BANK_OUT = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // Register view, region bit low
  typedef struct packed {
    logic       region;
    logic [3:0] unused;
    logic [2:0] sel;
  } csr_addr_t;

  // Memory view, region bit high
  typedef struct packed {
    logic             region;
    logic             bank;
    logic [DIM_W-1:0] row;
    logic [DIM_W-1:0] col;
  } mem_addr_t;

  // One host address, decoded by its top bit
  typedef union packed {
    csr_addr_t csr;
    mem_addr_t mem;
  } ntm_addr_u;

  // Request to the shared scratch memory
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } mem_req_t;

  // Engine configuration, sizes 1 to 8
  typedef struct packed {
    logic [DIM_W:0]    size_i;
    logic [DIM_W:0]    size_j;
    logic [DATA_W-1:0] modulo;
  } diff_cfg_t;

endpackage

`default_nettype wire
